/* source/id_cfg.svh */
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// datapath widths
`define ID_XLEN     32
`define ID_REG_AW   5

// link register and return offset for jal, jalr, bltzal, bgezal
`define ID_LINK_REG 31
`define ID_LINK_OFS 8

// instruction word fields
`define ID_F_OP     31:26
`define ID_F_RS     25:21
`define ID_F_RT     20:16
`define ID_F_RD     15:11
`define ID_F_SA     10:6
`define ID_F_FUNCT  5:0
`define ID_F_IMM    15:0
`define ID_F_INDEX  25:0

`endif

/* source/id_pkg.sv */
`include "id_cfg.svh"

package id_pkg;

    typedef logic [`ID_XLEN-1:0]   word_t;
    typedef logic [`ID_REG_AW-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_nor, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_t;

    typedef enum logic [3:0] {
        mem_none, mem_lb, mem_lbu, mem_lh, mem_lhu,
        mem_lw, mem_sb, mem_sh, mem_sw
    } mem_op_t;

    typedef enum logic [1:0] {
        src1_rs, src1_pc, src1_shamt
    } src1_sel_t;

    typedef enum logic [1:0] {
        src2_rt, src2_imm_sext, src2_imm_zext, src2_link
    } src2_sel_t;

    // linking forms reuse the compare kind of their plain version
    typedef enum logic [3:0] {
        br_none, br_beq, br_bne, br_bgez, br_bgtz,
        br_blez, br_bltz, br_j, br_jr
    } br_kind_t;

    typedef struct packed {
        alu_op_t   alu_op;
        mem_op_t   mem_op;
        src1_sel_t src1_sel;
        src2_sel_t src2_sel;
        logic      rf_we;
        reg_addr_t rf_waddr;
        logic      wb_from_mem;
    } ctrl_t;

    typedef struct packed {
        logic pc_misaligned;
        logic syscall;
        logic brk;
        logic invalid;
    } except_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } br_t;

    // operand selects are already resolved into src1/src2
    typedef struct packed {
        logic      valid;
        alu_op_t   alu_op;
        mem_op_t   mem_op;
        logic      rf_we;
        reg_addr_t rf_waddr;
        logic      wb_from_mem;
        word_t     src1;
        word_t     src2;
        word_t     store_data;
        except_t   except;
    } ex_bundle_t;

endpackage

/* source/id_control.sv */
`timescale 1ns/1ps
`include "id_cfg.svh"

module id_control (
    input  id_pkg::word_t    inst,
    input  id_pkg::word_t    id_pc,
    input  logic             ce,
    output id_pkg::ctrl_t    ctrl,
    output id_pkg::br_kind_t br_kind,
    output id_pkg::except_t  except_o
);
    import id_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    reg_addr_t  sa;
    logic       sa_zero;
    logic       r_fields_ok;
    logic       matched;
    logic       link;
    logic       is_syscall;
    logic       is_brk;

    assign opcode  = inst[`ID_F_OP];
    assign rs      = inst[`ID_F_RS];
    assign rt      = inst[`ID_F_RT];
    assign rd      = inst[`ID_F_RD];
    assign sa      = inst[`ID_F_SA];
    assign funct   = inst[`ID_F_FUNCT];
    assign sa_zero = (sa == '0);

    // must-be-zero fields of the special group
    always_comb begin
        case (funct)
            6'b00_0000, 6'b00_0010, 6'b00_0011: r_fields_ok = (rs == '0);
            6'b00_1000: r_fields_ok = (rt == '0) && (rd == '0) && sa_zero;
            6'b00_1001: r_fields_ok = (rt == '0) && sa_zero;
            6'b00_1100, 6'b00_1101: r_fields_ok = 1'b1;
            default: r_fields_ok = sa_zero;
        endcase
    end

    always_comb begin
        ctrl.alu_op      = alu_add;
        ctrl.mem_op      = mem_none;
        ctrl.src1_sel    = src1_rs;
        ctrl.src2_sel    = src2_rt;
        ctrl.rf_we       = 1'b0;
        ctrl.rf_waddr    = rd;
        ctrl.wb_from_mem = 1'b0;
        br_kind          = br_none;
        matched          = 1'b1;
        link             = 1'b0;
        is_syscall       = 1'b0;
        is_brk           = 1'b0;
        case (opcode) inside
            6'b00_0000: begin
                ctrl.rf_we = 1'b1;
                matched    = r_fields_ok;
                case (funct)
                    6'b10_0000, 6'b10_0001: ctrl.alu_op = alu_add;
                    6'b10_0010, 6'b10_0011: ctrl.alu_op = alu_sub;
                    6'b10_1010: ctrl.alu_op = alu_slt;
                    6'b10_1011: ctrl.alu_op = alu_sltu;
                    6'b10_0100: ctrl.alu_op = alu_and;
                    6'b10_0101: ctrl.alu_op = alu_or;
                    6'b10_0110: ctrl.alu_op = alu_xor;
                    6'b10_0111: ctrl.alu_op = alu_nor;
                    6'b00_0100: ctrl.alu_op = alu_sll;
                    6'b00_0110: ctrl.alu_op = alu_srl;
                    6'b00_0111: ctrl.alu_op = alu_sra;
                    6'b00_0000: begin
                        ctrl.alu_op   = alu_sll;
                        ctrl.src1_sel = src1_shamt;
                    end
                    6'b00_0010: begin
                        ctrl.alu_op   = alu_srl;
                        ctrl.src1_sel = src1_shamt;
                    end
                    6'b00_0011: begin
                        ctrl.alu_op   = alu_sra;
                        ctrl.src1_sel = src1_shamt;
                    end
                    6'b00_1000: begin
                        ctrl.rf_we = 1'b0;
                        br_kind    = br_jr;
                    end
                    6'b00_1001: begin
                        br_kind = br_jr;
                        link    = 1'b1;
                    end
                    6'b00_1100: begin
                        ctrl.rf_we = 1'b0;
                        is_syscall = 1'b1;
                    end
                    6'b00_1101: begin
                        ctrl.rf_we = 1'b0;
                        is_brk     = 1'b1;
                    end
                    default: matched = 1'b0;
                endcase
            end
            // regimm, rt[0] picks the compare and rt[4] the link
            6'b00_0001: begin
                br_kind = rt[0] ? br_bgez : br_bltz;
                link    = rt[4];
                matched = (rt[3:1] == 3'b000);
            end
            6'b00_0010: br_kind = br_j;
            6'b00_0011: begin
                br_kind = br_j;
                link    = 1'b1;
            end
            6'b00_0100: br_kind = br_beq;
            6'b00_0101: br_kind = br_bne;
            6'b00_0110: begin
                br_kind = br_blez;
                matched = (rt == '0);
            end
            6'b00_0111: begin
                br_kind = br_bgtz;
                matched = (rt == '0);
            end
            6'b00_1???: begin
                ctrl.rf_we    = 1'b1;
                ctrl.rf_waddr = rt;
                ctrl.src2_sel = src2_imm_sext;
                case (opcode[2:0])
                    3'b010: ctrl.alu_op = alu_slt;
                    3'b011: ctrl.alu_op = alu_sltu;
                    3'b111: ctrl.alu_op = alu_lui;
                    default: ctrl.alu_op = alu_add;
                endcase
                // logical immediates are zero extended
                case (opcode[2:0])
                    3'b100: ctrl.alu_op = alu_and;
                    3'b101: ctrl.alu_op = alu_or;
                    3'b110: ctrl.alu_op = alu_xor;
                    default: ;
                endcase
                if (opcode[2] && !(opcode[1] && opcode[0])) begin
                    ctrl.src2_sel = src2_imm_zext;
                end
            end
            6'b10_0???: begin
                ctrl.rf_we       = 1'b1;
                ctrl.rf_waddr    = rt;
                ctrl.src2_sel    = src2_imm_sext;
                ctrl.wb_from_mem = 1'b1;
                case (opcode[2:0])
                    3'b000: ctrl.mem_op = mem_lb;
                    3'b001: ctrl.mem_op = mem_lh;
                    3'b011: ctrl.mem_op = mem_lw;
                    3'b100: ctrl.mem_op = mem_lbu;
                    3'b101: ctrl.mem_op = mem_lhu;
                    default: matched = 1'b0;
                endcase
            end
            6'b10_1???: begin
                ctrl.src2_sel = src2_imm_sext;
                case (opcode[2:0])
                    3'b000: ctrl.mem_op = mem_sb;
                    3'b001: ctrl.mem_op = mem_sh;
                    3'b011: ctrl.mem_op = mem_sw;
                    default: matched = 1'b0;
                endcase
            end
            default: matched = 1'b0;
        endcase
        // link value pc + 8 goes to r31
        if (link) begin
            ctrl.src1_sel = src1_pc;
            ctrl.src2_sel = src2_link;
            ctrl.rf_we    = 1'b1;
            ctrl.rf_waddr = reg_addr_t'(`ID_LINK_REG);
        end
        if (!matched) begin
            ctrl.rf_we       = 1'b0;
            ctrl.mem_op      = mem_none;
            ctrl.wb_from_mem = 1'b0;
            br_kind          = br_none;
        end
        if (!ce) begin
            br_kind = br_none;
        end
    end

    assign except_o = '{
        pc_misaligned: (id_pc[1:0] != 2'b00),
        syscall:       is_syscall,
        brk:           is_brk,
        invalid:       ~matched
    };

endmodule

/* source/branch_unit.sv */
`timescale 1ns/1ps
`include "id_cfg.svh"

module branch_unit (
    input  id_pkg::br_kind_t br_kind,
    input  id_pkg::word_t    inst,
    input  id_pkg::word_t    id_pc,
    input  id_pkg::word_t    rdata1,
    input  id_pkg::word_t    rdata2,
    output id_pkg::br_t      br
);
    import id_pkg::*;

    logic [15:0] offset;
    word_t       pc_plus4;
    word_t       rel_target;
    word_t       abs_target;
    logic        rs_eq_rt;
    logic        rs_lt_z;
    logic        rs_gt_z;

    assign offset   = inst[`ID_F_IMM];
    assign pc_plus4 = id_pc + word_t'(4);

    // word offset relative to the delay slot
    assign rel_target = pc_plus4 + {{(`ID_XLEN - 18){offset[15]}}, offset, 2'b00};
    // jump stays in the region of the top four pc bits
    assign abs_target = {id_pc[`ID_XLEN-1 -: 4], inst[`ID_F_INDEX], 2'b00};

    assign rs_eq_rt = (rdata1 == rdata2);
    assign rs_lt_z  = rdata1[`ID_XLEN-1];
    assign rs_gt_z  = ~rs_lt_z && (rdata1 != '0);

    always_comb begin
        case (br_kind)
            br_beq:  br.taken = rs_eq_rt;
            br_bne:  br.taken = ~rs_eq_rt;
            br_bgez: br.taken = ~rs_lt_z;
            br_bgtz: br.taken = rs_gt_z;
            br_blez: br.taken = ~rs_gt_z;
            br_bltz: br.taken = rs_lt_z;
            br_j, br_jr: br.taken = 1'b1;
            default: br.taken = 1'b0;
        endcase
        case (br_kind)
            br_j:    br.target = abs_target;
            br_jr:   br.target = rdata1;
            br_none: br.target = '0;
            default: br.target = rel_target;
        endcase
    end

endmodule

/* source/operand_mux.sv */
`timescale 1ns/1ps
`include "id_cfg.svh"

module operand_mux (
    input  id_pkg::src1_sel_t src1_sel,
    input  id_pkg::src2_sel_t src2_sel,
    input  id_pkg::word_t     inst,
    input  id_pkg::word_t     id_pc,
    input  id_pkg::word_t     rdata1,
    input  id_pkg::word_t     rdata2,
    output id_pkg::word_t     src1,
    output id_pkg::word_t     src2
);
    import id_pkg::*;

    logic [15:0] imm;
    word_t       imm_sext;
    word_t       imm_zext;

    assign imm      = inst[`ID_F_IMM];
    assign imm_sext = {{(`ID_XLEN - 16){imm[15]}}, imm};
    assign imm_zext = {{(`ID_XLEN - 16){1'b0}}, imm};

    always_comb begin
        case (src1_sel)
            src1_pc:    src1 = id_pc;
            // shift amount from the sa field
            src1_shamt: src1 = word_t'(inst[`ID_F_SA]);
            default:    src1 = rdata1;
        endcase
    end

    always_comb begin
        case (src2_sel)
            src2_imm_sext: src2 = imm_sext;
            src2_imm_zext: src2 = imm_zext;
            src2_link:     src2 = word_t'(`ID_LINK_OFS);
            default:       src2 = rdata2;
        endcase
    end

endmodule

/* source/id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ce,
    input  id_pkg::ctrl_t      ctrl,
    input  id_pkg::word_t      src1,
    input  id_pkg::word_t      src2,
    input  id_pkg::word_t      store_data,
    input  id_pkg::except_t    except_i,
    output id_pkg::ex_bundle_t ex
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex.valid <= 1'b0;
        end else begin
            ex.valid <= ce;
        end
        // payload holds while ce is low
        if (ce) begin
            ex.alu_op      <= ctrl.alu_op;
            ex.mem_op      <= ctrl.mem_op;
            ex.rf_we       <= ctrl.rf_we;
            ex.rf_waddr    <= ctrl.rf_waddr;
            ex.wb_from_mem <= ctrl.wb_from_mem;
            ex.src1        <= src1;
            ex.src2        <= src2;
            ex.store_data  <= store_data;
            ex.except      <= except_i;
        end
    end

endmodule

/* source/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ce,
    input  id_pkg::word_t      inst,
    input  id_pkg::word_t      id_pc,
    input  id_pkg::word_t      rdata1,
    input  id_pkg::word_t      rdata2,
    output id_pkg::br_t        br,
    output id_pkg::ex_bundle_t ex
);
    import id_pkg::*;

    ctrl_t    ctrl;
    br_kind_t br_kind;
    except_t  except_flags;
    word_t    src1;
    word_t    src2;

    id_control u_id_control (
        .inst     (inst),
        .id_pc    (id_pc),
        .ce       (ce),
        .ctrl     (ctrl),
        .br_kind  (br_kind),
        .except_o (except_flags)
    );

    // same-cycle redirect to fetch
    branch_unit u_branch_unit (
        .br_kind (br_kind),
        .inst    (inst),
        .id_pc   (id_pc),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .br      (br)
    );

    operand_mux u_operand_mux (
        .src1_sel (ctrl.src1_sel),
        .src2_sel (ctrl.src2_sel),
        .inst     (inst),
        .id_pc    (id_pc),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .src1     (src1),
        .src2     (src2)
    );

    // rt value is the store data
    id_ex_reg u_id_ex_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .ce         (ce),
        .ctrl       (ctrl),
        .src1       (src1),
        .src2       (src2),
        .store_data (rdata2),
        .except_i   (except_flags),
        .ex         (ex)
    );

endmodule

/* testbench/id_stage_asserts.sv */
`timescale 1ns/1ps

module id_stage_asserts (
    input logic               clk,
    input logic               rst_n,
    input logic               ce,
    input id_pkg::br_t        br,
    input id_pkg::ex_bundle_t ex
);

    int failures = 0;

    // no redirect without a valid instruction
    assert property (@(posedge clk) !ce |-> !br.taken)
        else begin
            failures++;
            $error("br.taken is high while ce is low");
        end

    assert property (@(posedge clk) disable iff (!rst_n) !ce |=> !ex.valid)
        else begin
            failures++;
            $error("ex.valid is high one cycle after ce was low");
        end

    // register comes out of reset empty
    assert property (@(posedge clk) !rst_n |=> !ex.valid)
        else begin
            failures++;
            $error("ex.valid is high in the cycle after reset");
        end

endmodule

bind id_stage id_stage_asserts u_id_stage_asserts (
    .clk   (clk),
    .rst_n (rst_n),
    .ce    (ce),
    .br    (br),
    .ex    (ex)
);

/* testbench/tb_id_stage.sv */
`timescale 1ns/1ps
`include "id_cfg.svh"

module tb_id_stage;
    import id_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 2;
    localparam int NUM_CYCLES   = 5000;
    // whole run plus some slack
    localparam int TIMEOUT_NS   = (NUM_CYCLES + RESET_CYCLES + 20) * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'hc19401df;

    localparam logic [77:0] REG_FUNCTS = {6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26,
                                          6'h27, 6'h2a, 6'h2b, 6'h04, 6'h06, 6'h07};
    localparam logic [29:0] LOAD_OPS   = {6'h20, 6'h21, 6'h23, 6'h24, 6'h25};
    localparam logic [17:0] STORE_OPS  = {6'h28, 6'h29, 6'h2b};
    // mult, div and hi/lo moves
    localparam logic [47:0] DROPPED_FUNCTS = {6'h10, 6'h11, 6'h12, 6'h13,
                                              6'h18, 6'h19, 6'h1a, 6'h1b};

    logic       clk;
    logic       rst_n;
    logic       ce;
    word_t      inst;
    word_t      id_pc;
    word_t      rdata1;
    word_t      rdata2;
    br_t        br;
    ex_bundle_t ex;

    // expected results for the inputs of the current cycle
    logic      e_ce;
    logic      e_taken;
    logic      e_has_target;
    word_t     e_target;
    logic      e_ops;
    alu_op_t   e_alu;
    mem_op_t   e_mem;
    logic      e_we;
    reg_addr_t e_waddr;
    logic      e_wbm;
    word_t     e_src1;
    word_t     e_src2;
    word_t     e_store;
    except_t   e_exc;

    id_stage DUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .ce     (ce),
        .inst   (inst),
        .id_pc  (id_pc),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .br     (br),
        .ex     (ex)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the test did not finish within %0d ns", TIMEOUT_NS);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERR time %0t %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // kept instructions with legal zero fields, dropped ones, or raw words
    function automatic word_t make_inst();
        word_t       w;
        int unsigned k;
        w = $urandom;
        case ($urandom_range(9, 0))
            0: begin
                k        = $urandom_range(12, 0);
                w[31:26] = 6'h00;
                w[10:6]  = '0;
                w[5:0]   = REG_FUNCTS[6 * k +: 6];
            end
            1: begin
                k        = $urandom_range(2, 0);
                w[31:26] = 6'h00;
                w[25:21] = '0;
                w[5:0]   = (k == 0) ? 6'h00 : 6'(k + 1);
            end
            2: begin
                w[31:26] = 6'h00;
                w[20:16] = '0;
                w[10:6]  = '0;
                if ($urandom_range(1, 0) == 0) begin
                    w[15:11] = '0;
                    w[5:0]   = 6'h08;
                end else begin
                    w[5:0] = 6'h09;
                end
            end
            3: begin
                w[31:26] = 6'h00;
                w[5:0]   = ($urandom_range(1, 0) == 0) ? 6'h0c : 6'h0d;
            end
            4: begin
                w[31:26] = 6'h01;
                w[19:17] = 3'b000;
            end
            5: begin
                w[31:26] = 6'($urandom_range(7, 2));
                // blez and bgtz need rt zero
                if (w[28:27] == 2'b11) begin
                    w[20:16] = '0;
                end
            end
            6: w[31:26] = 6'($urandom_range(15, 8));
            7: begin
                k        = $urandom_range(4, 0);
                w[31:26] = LOAD_OPS[6 * k +: 6];
            end
            8: begin
                k        = $urandom_range(2, 0);
                w[31:26] = STORE_OPS[6 * k +: 6];
            end
            default: begin
                k = $urandom_range(2, 0);
                if (k == 0) begin
                    k        = $urandom_range(7, 0);
                    w[31:26] = 6'h00;
                    w[5:0]   = DROPPED_FUNCTS[6 * k +: 6];
                end else if (k == 1) begin
                    w[31:26] = 6'h10;
                end
            end
        endcase
        return w;
    endfunction

    task automatic drive_random();
        ce     = ($urandom_range(99, 0) < 80);
        inst   = make_inst();
        id_pc  = $urandom;
        if ($urandom_range(7, 0) != 0) begin
            id_pc[1:0] = 2'b00;
        end
        rdata1 = ($urandom_range(4, 0) == 0) ? '0 : word_t'($urandom);
        rdata2 = ($urandom_range(3, 0) == 0) ? rdata1 : word_t'($urandom);
    endtask

    task automatic compute_expected();
        logic [5:0] op;
        logic [5:0] fn;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] sa;
        word_t      sext;
        logic       ok;
        logic       link;
        br_kind_t   kind;
        op   = inst[31:26];
        rs   = inst[25:21];
        rt   = inst[20:16];
        rd   = inst[15:11];
        sa   = inst[10:6];
        fn   = inst[5:0];
        sext = {{16{inst[15]}}, inst[15:0]};
        ok   = 1'b1;
        link = 1'b0;
        kind = br_none;
        e_ops   = 1'b0;
        e_alu   = alu_add;
        e_mem   = mem_none;
        e_we    = 1'b0;
        e_waddr = rd;
        e_wbm   = 1'b0;
        e_src1  = rdata1;
        e_src2  = rdata2;
        e_exc   = '0;
        case (op)
            6'h00: begin
                e_we  = 1'b1;
                e_ops = 1'b1;
                case (fn)
                    6'h20, 6'h21: e_alu = alu_add;
                    6'h22, 6'h23: e_alu = alu_sub;
                    6'h24: e_alu = alu_and;
                    6'h25: e_alu = alu_or;
                    6'h26: e_alu = alu_xor;
                    6'h27: e_alu = alu_nor;
                    6'h2a: e_alu = alu_slt;
                    6'h2b: e_alu = alu_sltu;
                    6'h04, 6'h00: e_alu = alu_sll;
                    6'h06, 6'h02: e_alu = alu_srl;
                    6'h07, 6'h03: e_alu = alu_sra;
                    6'h08: begin
                        kind  = br_jr;
                        e_we  = 1'b0;
                        e_ops = 1'b0;
                        ok    = (rt == '0) && (rd == '0) && (sa == '0);
                    end
                    6'h09: begin
                        kind = br_jr;
                        link = 1'b1;
                        ok   = (rt == '0) && (sa == '0);
                    end
                    6'h0c, 6'h0d: begin
                        e_we          = 1'b0;
                        e_ops         = 1'b0;
                        e_exc.syscall = (fn == 6'h0c);
                        e_exc.brk     = (fn == 6'h0d);
                    end
                    default: ok = 1'b0;
                endcase
                // shift by constant takes sa and needs rs zero
                if (fn inside {6'h00, 6'h02, 6'h03}) begin
                    e_src1 = word_t'(sa);
                    ok     = (rs == '0);
                end else if (fn[5] || fn inside {6'h04, 6'h06, 6'h07}) begin
                    ok = ok && (sa == '0);
                end
            end
            6'h01: begin
                case (rt)
                    5'd0:  kind = br_bltz;
                    5'd1:  kind = br_bgez;
                    5'd16: kind = br_bltz;
                    5'd17: kind = br_bgez;
                    default: ok = 1'b0;
                endcase
                link = (rt == 5'd16) || (rt == 5'd17);
            end
            6'h02: kind = br_j;
            6'h03: begin
                kind = br_j;
                link = 1'b1;
            end
            6'h04: kind = br_beq;
            6'h05: kind = br_bne;
            6'h06: begin
                kind = br_blez;
                ok   = (rt == '0);
            end
            6'h07: begin
                kind = br_bgtz;
                ok   = (rt == '0);
            end
            6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
                e_we    = 1'b1;
                e_ops   = 1'b1;
                e_waddr = rt;
                e_src2  = sext;
                case (op)
                    6'h0a: e_alu = alu_slt;
                    6'h0b: e_alu = alu_sltu;
                    6'h0c: e_alu = alu_and;
                    6'h0d: e_alu = alu_or;
                    6'h0e: e_alu = alu_xor;
                    6'h0f: e_alu = alu_lui;
                    default: e_alu = alu_add;
                endcase
                if (op inside {6'h0c, 6'h0d, 6'h0e}) begin
                    e_src2 = {16'h0000, inst[15:0]};
                end
            end
            6'h20, 6'h21, 6'h23, 6'h24, 6'h25: begin
                e_we    = 1'b1;
                e_ops   = 1'b1;
                e_waddr = rt;
                e_wbm   = 1'b1;
                e_src2  = sext;
                case (op)
                    6'h20: e_mem = mem_lb;
                    6'h21: e_mem = mem_lh;
                    6'h23: e_mem = mem_lw;
                    6'h24: e_mem = mem_lbu;
                    default: e_mem = mem_lhu;
                endcase
            end
            6'h28, 6'h29, 6'h2b: begin
                e_ops  = 1'b1;
                e_src2 = sext;
                case (op)
                    6'h28: e_mem = mem_sb;
                    6'h29: e_mem = mem_sh;
                    default: e_mem = mem_sw;
                endcase
            end
            default: ok = 1'b0;
        endcase
        if (link) begin
            e_ops   = 1'b1;
            e_we    = 1'b1;
            e_alu   = alu_add;
            e_waddr = reg_addr_t'(`ID_LINK_REG);
            e_src1  = id_pc;
            e_src2  = word_t'(`ID_LINK_OFS);
        end
        if (!ok) begin
            e_ops = 1'b0;
            e_we  = 1'b0;
            e_mem = mem_none;
            e_wbm = 1'b0;
            kind  = br_none;
        end
        e_exc.invalid       = ~ok;
        e_exc.pc_misaligned = (id_pc[1:0] != 2'b00);
        if (!ce) begin
            kind = br_none;
        end
        e_ce    = ce;
        e_store = rdata2;
        case (kind)
            br_beq:  e_taken = (rdata1 == rdata2);
            br_bne:  e_taken = (rdata1 != rdata2);
            br_bgez: e_taken = ($signed(rdata1) >= 0);
            br_bgtz: e_taken = ($signed(rdata1) > 0);
            br_blez: e_taken = ($signed(rdata1) <= 0);
            br_bltz: e_taken = ($signed(rdata1) < 0);
            br_j, br_jr: e_taken = 1'b1;
            default: e_taken = 1'b0;
        endcase
        e_has_target = (kind != br_none);
        case (kind)
            br_j:    e_target = {id_pc[31:28], inst[25:0], 2'b00};
            br_jr:   e_target = rdata1;
            default: e_target = id_pc + 32'd4 + (sext << 2);
        endcase
    endtask

    // br for the held inputs, ex for what the last edge captured
    task automatic check_outputs();
        check_value("br.taken", e_taken, br.taken);
        if (e_has_target) begin
            check_value("br.target", e_target, br.target);
        end
        check_value("ex.valid", e_ce, ex.valid);
        if (e_ce) begin
            check_value("ex.except", e_exc, ex.except);
            check_value("ex.rf_we", e_we, ex.rf_we);
            check_value("ex.mem_op", e_mem, ex.mem_op);
            check_value("ex.wb_from_mem", e_wbm, ex.wb_from_mem);
            check_value("ex.store_data", e_store, ex.store_data);
            if (e_ops) begin
                check_value("ex.alu_op", e_alu, ex.alu_op);
                check_value("ex.src1", e_src1, ex.src1);
                check_value("ex.src2", e_src2, ex.src2);
                check_value("ex.rf_waddr", e_waddr, ex.rf_waddr);
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n  = 1'b0;
        ce     = 1'b0;
        inst   = '0;
        id_pc  = '0;
        rdata1 = '0;
        rdata2 = '0;
        compute_expected();
        repeat (RESET_CYCLES) @(negedge clk);
        check_outputs();
        rst_n = 1'b1;
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(negedge clk);
            check_outputs();
            drive_random();
            compute_expected();
        end
        @(negedge clk);
        check_outputs();
        if (DUT.u_id_stage_asserts.failures == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "%0d assertion failures", DUT.u_id_stage_asserts.failures);
        end
    end

endmodule

/* all.f */
+incdir+source
source/id_pkg.sv
source/id_control.sv
source/branch_unit.sv
source/operand_mux.sv
source/id_ex_reg.sv
source/id_stage.sv
testbench/id_stage_asserts.sv
testbench/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - include_dirs:
      - source
    files:
      - source/id_pkg.sv
      - source/id_control.sv
      - source/branch_unit.sv
      - source/operand_mux.sv
      - source/id_ex_reg.sv
      - source/id_stage.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/id_stage_asserts.sv
      - testbench/tb_id_stage.sv
